//--- tb.f
verilog/noc_pkg.sv
verilog/flit_fifo.sv
verilog/output_port.sv
verilog/spidergon_router.sv
verilog/spidergon_noc.sv
tests/tb_clock_gen.sv
tests/spidergon_tb.sv

//--- Bender.yml
package:
  name: spidergon_noc

sources:
  - verilog/noc_pkg.sv
  - verilog/flit_fifo.sv
  - verilog/output_port.sv
  - verilog/spidergon_router.sv
  - verilog/spidergon_noc.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/spidergon_tb.sv

//--- tests/spidergon_tb.sv
// directed regression of spidergon_noc; assumes single-flit packets and buf_depth credits per port
`timescale 1ns/100ps

module spidergon_tb;
	import noc_pkg::*;

	localparam int clk_period_ns = 20;
	localparam int num_random = 300;
	localparam int hotspot_burst = 4;
	localparam int bp_node = 5;
	localparam int bp_packets = 6;
	localparam int total_packets = num_nodes * num_nodes + num_nodes * hotspot_burst
		+ bp_packets + num_random;
	localparam int timeout_cycles = 40 * total_packets + 1000;
	// longest wait for the network to empty once injection has stopped
	localparam int drain_cycles = 500;

	logic clk;
	logic reset;
	link_t inject [num_nodes];
	logic [num_nodes-1:0] inject_credit;
	link_t eject [num_nodes];
	logic [num_nodes-1:0] eject_credit = '0;

	// running totals per node
	int sent_count [num_nodes];
	int credit_returns [num_nodes];
	int eject_count [num_nodes];
	int released_count [num_nodes];
	bit withhold [num_nodes];
	int error_count;

	// expected payloads indexed by src * num_nodes + dest
	logic [payload_w-1:0] exp_q [num_nodes * num_nodes][$];

	int rnd_src [num_random];
	int rnd_dst [num_random];
	logic [payload_w-1:0] rnd_pay [num_random];

	tb_clock_gen i_clk (
		.clk(clk),
		.reset(reset)
	);

	spidergon_noc i_dut (
		.clk(clk),
		.reset(reset),
		.inject(inject),
		.inject_credit(inject_credit),
		.eject(eject),
		.eject_credit(eject_credit)
	);

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name,
				expected, actual);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "run aborted");
	endtask

	function automatic int credits_left(input int src);
		return buf_depth - (sent_count[src] - credit_returns[src]);
	endfunction

	// true when nothing is in flight and every buffer and eject credit is back
	function automatic bit network_idle();
		for (int n = 0; n < num_nodes; n++)
		begin
			if (sent_count[n] != credit_returns[n])
			begin
				return 1'b0;
			end
			if (eject_count[n] != released_count[n])
			begin
				return 1'b0;
			end
		end
		for (int q = 0; q < num_nodes * num_nodes; q++)
		begin
			if (exp_q[q].size() != 0)
			begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// returns once the network is idle or drain_cycles have passed
	task automatic wait_drained();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!network_idle() && (waited < drain_cycles))
		begin
			@(negedge clk);
			waited++;
		end
	endtask

	// waits for an injection credit and then drives valid for one cycle
	task automatic send_packet(input int src, input int dest, input logic [payload_w-1:0] payload);
		flit_t f;
		f.dest = node_id_t'(dest);
		f.src = node_id_t'(src);
		f.payload = payload;
		@(negedge clk);
		while (credits_left(src) == 0)
		begin
			@(negedge clk);
		end
		inject[src].flit = f;
		inject[src].valid = 1'b1;
		exp_q[src * num_nodes + dest].push_back(payload);
		sent_count[src]++;
		@(negedge clk);
		inject[src].valid = 1'b0;
	endtask

	// eject and inject_credit are registered, so the pre-edge values cover the whole cycle
	always @(posedge clk)
	begin
		int pair;
		logic [payload_w-1:0] exp_pay;
		if (!reset)
		begin
			for (int n = 0; n < num_nodes; n++)
			begin
				if (inject_credit[n])
				begin
					credit_returns[n]++;
					if (credit_returns[n] > sent_count[n])
					begin
						abort_run($sformatf("node %0d returned an inject credit with no flit sent", n));
					end
				end
				if (eject[n].valid)
				begin
					check_equal($sformatf("eject[%0d].flit.dest", n), n, eject[n].flit.dest);
					pair = int'(eject[n].flit.src) * num_nodes + n;
					if (exp_q[pair].size() == 0)
					begin
						abort_run($sformatf("node %0d ejected a packet from node %0d that was not expected",
							n, eject[n].flit.src));
					end
					else
					begin
						exp_pay = exp_q[pair].pop_front();
						check_equal($sformatf("eject[%0d].flit.payload", n), exp_pay,
							eject[n].flit.payload);
					end
					eject_count[n]++;
				end
			end
		end
	end

	// eject credit goes back a cycle after the eject unless that node is held
	always @(negedge clk)
	begin
		for (int n = 0; n < num_nodes; n++)
		begin
			if (!reset && !withhold[n] && (eject_count[n] > released_count[n]))
			begin
				eject_credit[n] <= 1'b1;
				released_count[n]++;
			end
			else
			begin
				eject_credit[n] <= 1'b0;
			end
		end
	end

	task automatic reset_state_check();
		@(negedge clk);
		while (reset)
		begin
			for (int n = 0; n < num_nodes; n++)
			begin
				check_equal($sformatf("eject[%0d].valid", n), 0, eject[n].valid);
			end
			check_equal("inject_credit", 0, inject_credit);
			@(negedge clk);
		end
		repeat (5)
		begin
			for (int n = 0; n < num_nodes; n++)
			begin
				check_equal($sformatf("eject[%0d].valid", n), 0, eject[n].valid);
			end
			check_equal("inject_credit", 0, inject_credit);
			@(negedge clk);
		end
	endtask

	task automatic all_pairs_sweep();
		int credits_before;
		int ejects_before;
		for (int s = 0; s < num_nodes; s++)
		begin
			for (int d = 0; d < num_nodes; d++)
			begin
				credits_before = credit_returns[s];
				ejects_before = eject_count[d];
				send_packet(s, d, payload_w'(s * num_nodes + d));
				wait_drained();
				check_equal($sformatf("inject_credit[%0d] pulses", s), credits_before + 1,
					credit_returns[s]);
				check_equal($sformatf("eject[%0d] count", d), ejects_before + 1, eject_count[d]);
			end
		end
	endtask

	task automatic hotspot_contention();
		int ejects_before;
		ejects_before = eject_count[0];
		for (int n = 0; n < num_nodes; n++)
		begin
			fork
				automatic int s = n;
				begin
					for (int k = 0; k < hotspot_burst; k++)
					begin
						send_packet(s, 0, payload_w'(10'h100 + s * hotspot_burst + k));
					end
				end
			join_none
		end
		wait fork;
		wait_drained();
		check_equal("eject[0] count", ejects_before + num_nodes * hotspot_burst, eject_count[0]);
	endtask

	task automatic eject_backpressure();
		int ejects_before;
		ejects_before = eject_count[bp_node];
		withhold[bp_node] = 1'b1;
		for (int i = 0; i < bp_packets; i++)
		begin
			fork
				automatic int s = (bp_node + 1 + i) % num_nodes;
				automatic int k = i;
				begin
					send_packet(s, bp_node, payload_w'(10'h200 + k));
				end
			join_none
		end
		wait fork;
		while (eject_count[bp_node] - ejects_before < buf_depth)
		begin
			@(negedge clk);
		end
		// the sink gets no credits during this window
		repeat (40) @(negedge clk);
		check_equal("eject count while credits held", buf_depth,
			eject_count[bp_node] - ejects_before);
		withhold[bp_node] = 1'b0;
		wait_drained();
		check_equal("eject count after release", bp_packets, eject_count[bp_node] - ejects_before);
	endtask

	task automatic random_traffic();
		int total_sent;
		int total_ejected;
		for (int i = 0; i < num_random; i++)
		begin
			rnd_src[i] = $urandom % num_nodes;
			rnd_dst[i] = $urandom % num_nodes;
			rnd_pay[i] = payload_w'($urandom);
		end
		for (int n = 0; n < num_nodes; n++)
		begin
			fork
				automatic int s = n;
				begin
					for (int i = 0; i < num_random; i++)
					begin
						if (rnd_src[i] == s)
						begin
							send_packet(s, rnd_dst[i], rnd_pay[i]);
						end
					end
				end
			join_none
		end
		wait fork;
		wait_drained();
		total_sent = 0;
		total_ejected = 0;
		for (int n = 0; n < num_nodes; n++)
		begin
			total_sent += sent_count[n];
			total_ejected += eject_count[n];
		end
		check_equal("packets delivered", total_sent, total_ejected);
		for (int q = 0; q < num_nodes * num_nodes; q++)
		begin
			check_equal($sformatf("exp_q[%0d].size", q), 0, exp_q[q].size());
		end
	endtask

	initial
	begin
		#(timeout_cycles * clk_period_ns);
		$display("watchdog expired: the run timed out before all tests finished");
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	initial
	begin
		error_count = 0;
		void'($urandom(79));
		for (int n = 0; n < num_nodes; n++)
		begin
			inject[n] = '0;
			withhold[n] = 1'b0;
		end
		reset_state_check();
		all_pairs_sweep();
		hotspot_contention();
		eject_backpressure();
		random_traffic();
		if (error_count == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
// free-running 20 ns clock; reset is held high for the first 10 rising edges
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	localparam int half_period_ns = 10;
	localparam int reset_cycles = 10;

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#half_period_ns clk = ~clk;
		end
	end

	// release on a falling edge so the DUT sees a clean synchronous deassert
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- verilog/spidergon_noc.sv
// eight-node ring with across links; inject and eject follow the same credit rules as the links
`timescale 1ns/100ps

module spidergon_noc (
	input logic clk,
	input logic reset,
	input noc_pkg::link_t inject [noc_pkg::num_nodes],
	output logic [noc_pkg::num_nodes-1:0] inject_credit,
	output noc_pkg::link_t eject [noc_pkg::num_nodes],
	input logic [noc_pkg::num_nodes-1:0] eject_credit
);
	import noc_pkg::*;

	link_t in_link [num_nodes][num_ports];
	link_t out_link [num_nodes][num_ports];
	logic [num_ports-1:0] in_credit [num_nodes];
	logic [num_ports-1:0] out_credit [num_nodes];

	genvar n;

	generate
		for (n = 0; n < num_nodes; n++)
		begin : g_node
			localparam int next = (n + 1) % num_nodes;
			localparam int prev = (n + num_nodes - 1) % num_nodes;
			localparam int opp = (n + num_nodes / 2) % num_nodes;

			// flits forward
			assign in_link[n][port_acw] = out_link[prev][port_cw];
			assign in_link[n][port_cw] = out_link[next][port_acw];
			assign in_link[n][port_across] = out_link[opp][port_across];
			assign in_link[n][port_local] = inject[n];

			// credits back along the same links
			assign out_credit[n][port_cw] = in_credit[next][port_acw];
			assign out_credit[n][port_acw] = in_credit[prev][port_cw];
			assign out_credit[n][port_across] = in_credit[opp][port_across];
			assign out_credit[n][port_local] = eject_credit[n];

			// local port faces the outside
			assign inject_credit[n] = in_credit[n][port_local];
			assign eject[n] = out_link[n][port_local];

			spidergon_router #(
				.node_id(node_id_t'(n))
			) i_router (
				.clk(clk),
				.reset(reset),
				.in_link(in_link[n]),
				.in_credit(in_credit[n]),
				.out_link(out_link[n]),
				.out_credit(out_credit[n])
			);
		end
	endgenerate

endmodule

//--- verilog/spidergon_router.sv
// single-flit packets only; one buffer per input and routing by noc_pkg::route_port on the buffer head
`timescale 1ns/100ps

module spidergon_router #(
	parameter noc_pkg::node_id_t node_id = '0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::link_t in_link [noc_pkg::num_ports],
	output logic [noc_pkg::num_ports-1:0] in_credit,
	output noc_pkg::link_t out_link [noc_pkg::num_ports],
	input logic [noc_pkg::num_ports-1:0] out_credit
);
	import noc_pkg::*;

	flit_t head [num_ports];
	logic [num_ports-1:0] not_empty;
	logic [num_ports-1:0] pop;
	port_t route [num_ports];

	// req and grant are indexed by output with one bit per input
	logic [num_ports-1:0] req [num_ports];
	logic [num_ports-1:0] grant [num_ports];

	genvar p;
	genvar o;

	generate
		for (p = 0; p < num_ports; p++)
		begin : g_in
			flit_fifo i_fifo (
				.clk(clk),
				.reset(reset),
				.wr(in_link[p]),
				.pop(pop[p]),
				.head(head[p]),
				.not_empty(not_empty[p]),
				.credit(in_credit[p])
			);

			// route of the head is only meaningful while not_empty
			assign route[p] = route_port(node_id, head[p].dest);
		end
	endgenerate

	// each waiting head asks exactly one output
	always_comb
	begin
		for (int oi = 0; oi < num_ports; oi++)
		begin
			for (int pi = 0; pi < num_ports; pi++)
			begin
				req[oi][pi] = not_empty[pi] && (route[pi] == port_t'(oi));
			end
		end
	end

	// a grant from any output pops the buffer it picked
	always_comb
	begin
		pop = '0;
		for (int oi = 0; oi < num_ports; oi++)
		begin
			pop = pop | grant[oi];
		end
	end

	generate
		for (o = 0; o < num_ports; o++)
		begin : g_out
			output_port i_out (
				.clk(clk),
				.reset(reset),
				.req(req[o]),
				.cand(head),
				.grant(grant[o]),
				.out(out_link[o]),
				.credit_in(out_credit[o])
			);
		end
	endgenerate

	generate
		for (p = 0; p < num_ports; p++)
		begin : g_chk
			// a popped flit leaves unchanged on its routed output in the next cycle
			a_pop_granted: assert property (@(posedge clk) disable iff (reset)
				pop[p] |=> (out_link[$past(route[p])].valid
					&& (out_link[$past(route[p])].flit == $past(head[p]))));
		end
	endgenerate

endmodule

//--- verilog/output_port.sv
// one router output; sends at most one flit per cycle and only while it holds a credit
`timescale 1ns/100ps

module output_port (
	input logic clk,
	input logic reset,
	input logic [noc_pkg::num_ports-1:0] req,
	input noc_pkg::flit_t cand [noc_pkg::num_ports],
	output logic [noc_pkg::num_ports-1:0] grant,
	output noc_pkg::link_t out,
	input logic credit_in
);
	import noc_pkg::*;

	localparam int cnt_w = $clog2(buf_depth + 1);

	logic [cnt_w-1:0] credits;
	port_t last;
	port_t sel;
	logic send;
	logic out_valid;
	flit_t out_flit;

	// round robin, search starts just after the last winner
	always_comb
	begin
		int idx;
		grant = '0;
		sel = last;
		idx = 0;
		if (credits != '0)
		begin
			for (int i = 1; i <= num_ports; i++)
			begin
				idx = (int'(last) + i) % num_ports;
				if (req[idx] && (grant == '0))
				begin
					grant[idx] = 1'b1;
					sel = port_t'(idx);
				end
			end
		end
	end

	assign send = |grant;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credits <= cnt_w'(buf_depth);
			// so input 0 wins first after reset
			last <= port_t'(num_ports - 1);
			out_valid <= 1'b0;
		end
		else
		begin
			// a send and a returning credit in one cycle cancel out
			case ({send, credit_in})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (send)
			begin
				last <= sel;
			end
			out_valid <= send;
		end
	end

	// flit register
	always_ff @(posedge clk)
	begin
		if (send)
		begin
			out_flit <= cand[sel];
		end
	end

	assign out = {out_valid, out_flit};

	// more credits than downstream slots means a stray credit pulse
	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= cnt_w'(buf_depth));

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

endmodule

//--- verilog/flit_fifo.sv
// input buffer of buf_depth flits; upstream must honour credits, a write while full is an error
`timescale 1ns/100ps

module flit_fifo (
	input logic clk,
	input logic reset,
	input noc_pkg::link_t wr,
	input logic pop,
	output noc_pkg::flit_t head,
	output logic not_empty,
	output logic credit
);
	import noc_pkg::*;

	localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
	localparam int cnt_w = $clog2(buf_depth + 1);

	flit_t mem [buf_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;

	// circular increment, depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(buf_depth - 1))
		begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wr.valid)
		begin
			mem[wr_ptr] <= wr.flit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (wr.valid)
			begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop)
			begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr.valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per freed slot, a cycle after the pop
			credit <= pop;
		end
	end

	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);

	// a write into a full buffer means the sender ran past its credits
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr.valid |-> (count < cnt_w'(buf_depth)));

endmodule

//--- verilog/noc_pkg.sv
// num_nodes must be an even power of two; packets are single flits, one channel per port
package noc_pkg;

	// network size
	localparam int num_nodes = 8;
	localparam int node_id_w = $clog2(num_nodes);
	localparam int payload_w = 10;

	// slots per input buffer, also the starting credit of each output
	localparam int buf_depth = 2;

	localparam int num_ports = 4;

	typedef logic [$clog2(num_ports)-1:0] port_t;
	typedef logic [node_id_w-1:0] node_id_t;

	// port indices, shared by inputs and outputs
	localparam port_t port_acw = 2'd0;
	localparam port_t port_cw = 2'd1;
	localparam port_t port_across = 2'd2;
	localparam port_t port_local = 2'd3;

	// 16-bit flit with destination in the top bits
	typedef struct packed {
		node_id_t dest;
		node_id_t src;
		logic [payload_w-1:0] payload;
	} flit_t;

	// one direction of a link, credit runs back on its own wire
	typedef struct packed {
		logic valid;
		flit_t flit;
	} link_t;

	// across first, then around the ring
	// r is the clockwise distance from the current node to the destination
	function automatic port_t route_port(input node_id_t cur, input node_id_t dest);
		node_id_t r;
		r = dest - cur;
		if (r == '0)
		begin
			return port_local;
		end
		else if (r <= node_id_t'(num_nodes / 4))
		begin
			return port_cw;
		end
		else if (r >= node_id_t'(num_nodes - num_nodes / 4))
		begin
			return port_acw;
		end
		else
		begin
			// at most one ring hop remains on the far side
			return port_across;
		end
	endfunction

endpackage
